//--- logic/fma_defs.svh
// Width and bias macros for the binary32 fused multiply-add datapath
// Included by the package and by every RTL file that sizes a datapath signal
`ifndef FMA_DEFS_SVH
`define FMA_DEFS_SVH

// Encoded binary32 fields
`define FMA_EXP_BITS 8
`define FMA_MAN_BITS 23
`define FMA_WIDTH (`FMA_EXP_BITS + `FMA_MAN_BITS + 1)
`define FMA_BIAS 127

// Precision p counts the hidden bit
`define FMA_PREC (`FMA_MAN_BITS + 1)
// Adder holds 3p+4 bits, LZC searches the lower 2p+3
`define FMA_SUM_WIDTH (3 * `FMA_PREC + 4)
`define FMA_LOWER_WIDTH (2 * `FMA_PREC + 3)
`define FMA_LZC_WIDTH 6
// Signed internal exponent with two guard bits
`define FMA_EXP_WIDTH (`FMA_EXP_BITS + 2)
`define FMA_SHAMT_WIDTH 7

`endif

//--- logic/fma_pkg.sv
// Shared types of the fused multiply-add unit
// Import with a wildcard in the module header
`default_nettype none

`include "fma_defs.svh"

package fma_pkg;

  // Operation select, op_mod flips the addend sign on top of it
  typedef enum logic [1:0] {
    FMADD  = 2'd0,
    FNMSUB = 2'd1,
    ADD    = 2'd2,
    MUL    = 2'd3
  } fp_op_e;

  // IEEE 754 rounding directions
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } round_mode_e;

  typedef struct packed {
    logic                     sign;
    logic [`FMA_EXP_BITS-1:0] exponent;
    logic [`FMA_MAN_BITS-1:0] mantissa;
  } fp_t;

  // Operand class, exactly one of the first five is set
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  // Exception flags, no divide-by-zero in this unit
  typedef struct packed {
    logic nv;
    logic of;
    logic uf;
    logic nx;
  } status_t;

endpackage

`default_nettype wire

//--- logic/fma_oper_if.sv
// Adjusted operands and their class, from operand prep to the align/add stage
`default_nettype none

`include "fma_defs.svh"

interface fma_oper_if
  import fma_pkg::*;
();

  // Operands after the operation table, a*b + c
  fp_t      operand_a;
  fp_t      operand_b;
  fp_t      operand_c;
  fp_info_t info_a;
  fp_info_t info_b;
  fp_info_t info_c;
  // Product and addend signs differ
  logic     eff_sub;

  modport prep (
    output operand_a, operand_b, operand_c,
    output info_a, info_b, info_c,
    output eff_sub
  );

  modport align (
    input operand_a, operand_b, operand_c,
    input info_a, info_b, info_c,
    input eff_sub
  );

endinterface

`default_nettype wire

//--- logic/fma_mid_if.sv
// Mid-pipeline payload between align/add and normalize/round
// One instance feeds the stage register, a second one leaves it
`default_nettype none

`include "fma_defs.svh"

interface fma_mid_if
  import fma_pkg::*;
();

  // ----------------------------
  // Adder side
  // ----------------------------
  logic                               eff_sub;
  logic signed [`FMA_EXP_WIDTH-1:0]   exp_prod;
  logic signed [`FMA_EXP_WIDTH-1:0]   exp_diff;
  logic signed [`FMA_EXP_WIDTH-1:0]   tent_exp;
  logic        [`FMA_SHAMT_WIDTH-1:0] add_shamt;
  // Addend bits lost in the alignment shift
  logic                               sticky;
  logic        [`FMA_SUM_WIDTH-1:0]   sum;
  logic                               final_sign;

  // ----------------------------
  // Operand prep side
  // ----------------------------
  round_mode_e                        rnd_mode;
  logic                               is_special;
  fp_t                                special_result;
  status_t                            special_status;

  modport datapath (
    output eff_sub, exp_prod, exp_diff, tent_exp, add_shamt, sticky, sum, final_sign
  );

  modport spec (
    output rnd_mode, is_special, special_result, special_status
  );

  modport norm (
    input eff_sub, exp_prod, exp_diff, tent_exp, add_shamt, sticky, sum, final_sign,
    input rnd_mode, is_special, special_result, special_status
  );

endinterface

`default_nettype wire

//--- logic/fma_operand_prep.sv
// Operation select, operand classification and special-case detection
// Purely combinational, drives the operand bundle and the special part of the payload
`default_nettype none

`include "fma_defs.svh"

module fma_operand_prep import fma_pkg::*; (
  input  fp_t [2:0]   operands_i,
  input  fp_op_e      op_i,
  input  logic        op_mod_i,
  input  round_mode_e rnd_mode_i,
  fma_oper_if.prep    oper,
  fma_mid_if.spec     mid
);

  // Sort one operand into its IEEE class
  function automatic fp_info_t classify(input fp_t value);
    fp_info_t info;
    logic     exp_zero;
    logic     exp_ones;
    logic     man_zero;
    exp_zero           = (value.exponent == '0);
    exp_ones           = (value.exponent == '1);
    man_zero           = (value.mantissa == '0);
    info.is_normal     = !exp_zero && !exp_ones;
    info.is_subnormal  = exp_zero && !man_zero;
    info.is_zero       = exp_zero && man_zero;
    info.is_inf        = exp_ones && man_zero;
    info.is_nan        = exp_ones && !man_zero;
    // Quiet bit is the mantissa MSB
    info.is_signalling = info.is_nan && !value.mantissa[`FMA_MAN_BITS-1];
    return info;
  endfunction

  // ----------------------------
  // Operation adjustment
  // ----------------------------
  always_comb begin : op_select
    oper.operand_a = operands_i[0];
    oper.operand_b = operands_i[1];
    oper.operand_c = operands_i[2];
    oper.info_a    = classify(operands_i[0]);
    oper.info_b    = classify(operands_i[1]);
    oper.info_c    = classify(operands_i[2]);
    // SUB / FMSUB / FNMADD
    oper.operand_c.sign = operands_i[2].sign ^ op_mod_i;
    unique case (op_i)
      FMADD: begin
      end
      // Negated product
      FNMSUB: oper.operand_a.sign = ~operands_i[0].sign;
      // Multiplicand forced to +1.0
      ADD: begin
        oper.operand_a = '{sign: 1'b0, exponent: `FMA_EXP_BITS'(`FMA_BIAS), mantissa: '0};
        oper.info_a    = '{is_normal: 1'b1, default: 1'b0};
      end
      // Addend +0 under RDN, -0 otherwise, keeps the sign of a zero product
      MUL: begin
        oper.operand_c = '{sign: (rnd_mode_i != RDN), exponent: '0, mantissa: '0};
        oper.info_c    = '{is_zero: 1'b1, default: 1'b0};
      end
    endcase
  end

  assign oper.eff_sub = oper.operand_a.sign ^ oper.operand_b.sign ^ oper.operand_c.sign;
  assign mid.rnd_mode = rnd_mode_i;

  // ----------------------------
  // Special cases
  // ----------------------------
  logic prod_inf;
  logic any_nan;
  logic any_snan;

  assign prod_inf = oper.info_a.is_inf || oper.info_b.is_inf;
  assign any_nan  = oper.info_a.is_nan || oper.info_b.is_nan || oper.info_c.is_nan;
  assign any_snan = oper.info_a.is_signalling || oper.info_b.is_signalling
                    || oper.info_c.is_signalling;

  always_comb begin : special_cases
    // Canonical qNaN unless an infinity is chosen below
    mid.special_result = '{sign: 1'b0, exponent: '1,
                           mantissa: {1'b1, {(`FMA_MAN_BITS-1){1'b0}}}};
    mid.special_status = '0;
    mid.is_special     = 1'b0;
    // inf * 0 is invalid even with a quiet NaN addend
    if ((oper.info_a.is_inf && oper.info_b.is_zero)
        || (oper.info_a.is_zero && oper.info_b.is_inf)) begin
      mid.is_special     = 1'b1;
      mid.special_status.nv = 1'b1;
    end else if (any_nan) begin
      mid.is_special        = 1'b1;
      mid.special_status.nv = any_snan;
    end else if (prod_inf || oper.info_c.is_inf) begin
      mid.is_special = 1'b1;
      if (prod_inf && oper.info_c.is_inf && oper.eff_sub) begin
        // inf - inf
        mid.special_status.nv = 1'b1;
      end else if (prod_inf) begin
        mid.special_result = '{sign: oper.operand_a.sign ^ oper.operand_b.sign,
                               exponent: '1, mantissa: '0};
      end else begin
        mid.special_result = '{sign: oper.operand_c.sign, exponent: '1, mantissa: '0};
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/fma_align_add.sv
// Exponent path, mantissa product, addend alignment and the 3p+4 bit adder
// Combinational, feeds the adder part of the mid-stage payload
`default_nettype none

`include "fma_defs.svh"

module fma_align_add import fma_pkg::*; (
  fma_oper_if.align   oper,
  fma_mid_if.datapath mid
);

  logic signed [`FMA_EXP_WIDTH-1:0]   exp_a, exp_b, exp_c;
  logic signed [`FMA_EXP_WIDTH-1:0]   exp_addend, exp_product, exp_diff;
  logic        [`FMA_SHAMT_WIDTH-1:0] addend_shamt;
  logic        [`FMA_PREC-1:0]        man_a, man_b, man_c;
  logic        [2*`FMA_PREC-1:0]      product;
  logic        [`FMA_SUM_WIDTH-1:0]   product_shifted;
  logic        [`FMA_SUM_WIDTH-1:0]   addend_aligned;
  logic        [`FMA_PREC-1:0]        addend_sticky_bits;
  logic        [`FMA_SUM_WIDTH-1:0]   addend_shifted;
  logic                               carry_in;
  logic        [`FMA_SUM_WIDTH:0]     sum_raw;
  logic        [`FMA_SUM_WIDTH:0]     sum_abs;
  logic                               tent_sign;

  // ----------------------------
  // Exponents, kept biased
  // ----------------------------
  assign exp_a = $signed({2'b00, oper.operand_a.exponent});
  assign exp_b = $signed({2'b00, oper.operand_b.exponent});
  assign exp_c = $signed({2'b00, oper.operand_c.exponent});

  // Subnormal addend sits at encoded exponent 1
  assign exp_addend  = exp_c + `FMA_EXP_WIDTH'(!oper.info_c.is_normal);
  // Zero product takes the minimum exponent
  assign exp_product = (oper.info_a.is_zero || oper.info_b.is_zero)
                       ? `FMA_EXP_WIDTH'(2 - `FMA_BIAS)
                       : `FMA_EXP_WIDTH'(exp_a + exp_b + oper.info_a.is_subnormal
                                         + oper.info_b.is_subnormal - `FMA_BIAS);
  assign exp_diff    = exp_addend - exp_product;

  assign mid.exp_prod = exp_product;
  assign mid.exp_diff = exp_diff;
  assign mid.tent_exp = (exp_diff > 0) ? exp_addend : exp_product;

  // Right shift of the addend, saturated at both ends
  always_comb begin : addend_shift_amount
    if (exp_diff <= -(2 * `FMA_PREC + 1)) begin
      // Addend only reaches the sticky bit
      addend_shamt = `FMA_SHAMT_WIDTH'(`FMA_SUM_WIDTH);
    end else if (exp_diff <= `FMA_PREC + 2) begin
      addend_shamt = `FMA_SHAMT_WIDTH'(`FMA_PREC + 3 - exp_diff);
    end else begin
      // Product only reaches the sticky bit
      addend_shamt = '0;
    end
  end
  assign mid.add_shamt = addend_shamt;

  // ----------------------------
  // Product and addend
  // ----------------------------
  assign man_a   = {oper.info_a.is_normal, oper.operand_a.mantissa};
  assign man_b   = {oper.info_b.is_normal, oper.operand_b.mantissa};
  assign man_c   = {oper.info_c.is_normal, oper.operand_c.mantissa};
  assign product = man_a * man_b;

  // p+2 zeros, 2p product, round and sticky slots
  assign product_shifted = {{(`FMA_PREC+2){1'b0}}, product, 2'b00};

  // Up to p addend bits fall off the right and fold into sticky
  assign {addend_aligned, addend_sticky_bits} =
      {man_c, {`FMA_SUM_WIDTH{1'b0}}} >> addend_shamt;
  assign mid.sticky = |addend_sticky_bits;

  // One's complement on subtraction, +1 only if nothing sticky was lost
  assign addend_shifted = oper.eff_sub ? ~addend_aligned : addend_aligned;
  assign carry_in       = oper.eff_sub && !mid.sticky;

  // ----------------------------
  // Adder and sign fix
  // ----------------------------
  assign sum_raw = product_shifted + addend_shifted + carry_in;
  // No carry out on subtraction means the sum went negative
  assign sum_abs = (oper.eff_sub && !sum_raw[`FMA_SUM_WIDTH]) ? -sum_raw : sum_raw;
  assign mid.sum = sum_abs[`FMA_SUM_WIDTH-1:0];

  assign tent_sign   = oper.operand_a.sign ^ oper.operand_b.sign;
  assign mid.eff_sub = oper.eff_sub;
  assign mid.final_sign = oper.eff_sub ? (sum_raw[`FMA_SUM_WIDTH] == tent_sign) : tent_sign;

endmodule

`default_nettype wire

//--- logic/fma_normalize_round.sv
// Leading-zero count, normalization, rounding and flags of the second stage
// Reads the registered mid payload, result goes to the output register
`default_nettype none

`include "fma_defs.svh"

module fma_normalize_round import fma_pkg::*; (
  fma_mid_if.norm mid,
  output fp_t     result_o,
  output status_t status_o
);

  logic        [`FMA_LOWER_WIDTH-1:0] sum_lower;
  logic        [`FMA_LZC_WIDTH-1:0]   lzc_cnt;
  logic                               lzc_empty;
  logic signed [`FMA_LZC_WIDTH:0]     lzc_sgn;
  logic        [`FMA_SHAMT_WIDTH-1:0] norm_shamt;
  logic signed [`FMA_EXP_WIDTH-1:0]   norm_exp;
  logic        [`FMA_SUM_WIDTH:0]     sum_shifted;
  logic        [`FMA_PREC:0]          final_man;
  logic        [`FMA_LOWER_WIDTH-1:0] sticky_bits;
  logic signed [`FMA_EXP_WIDTH-1:0]   final_exp;
  logic                               sticky_after;
  logic                               of_before, of_after, uf_after;
  logic        [`FMA_EXP_BITS-1:0]    pre_exp;
  logic        [`FMA_MAN_BITS-1:0]    pre_man;
  logic        [`FMA_WIDTH-2:0]       pre_abs, rounded_abs;
  logic        [1:0]                  rs;
  logic                               round_up;
  logic                               exact_zero;
  logic                               rounded_sign;
  status_t                            regular_status;

  // ----------------------------
  // Leading-zero count
  // ----------------------------
  assign sum_lower = mid.sum[`FMA_LOWER_WIDTH-1:0];
  assign lzc_empty = ~|sum_lower;

  // Walk up from the LSB, the highest set bit writes last
  always_comb begin : lzc
    lzc_cnt = '0;
    for (int i = 0; i < `FMA_LOWER_WIDTH; i++) begin
      if (sum_lower[i]) begin
        lzc_cnt = `FMA_LZC_WIDTH'(`FMA_LOWER_WIDTH - 1 - i);
      end
    end
  end
  assign lzc_sgn = $signed({1'b0, lzc_cnt});

  // ----------------------------
  // Normalization
  // ----------------------------
  always_comb begin : norm_shift_amount
    // Product-anchored, or cancellation possible
    if ((mid.exp_diff <= 0) || (mid.eff_sub && (mid.exp_diff <= 2))) begin
      if ((mid.exp_prod - lzc_sgn + 1 >= 0) && !lzc_empty) begin
        norm_shamt = `FMA_SHAMT_WIDTH'(`FMA_PREC + 2 + lzc_cnt);
        norm_exp   = `FMA_EXP_WIDTH'(mid.exp_prod - lzc_sgn + 1);
      end else begin
        // Subnormal, stop the shift at the minimum exponent
        norm_shamt = `FMA_SHAMT_WIDTH'(`FMA_PREC + 2 + mid.exp_prod);
        norm_exp   = '0;
      end
    end else begin
      // Addend-anchored, undo the alignment
      norm_shamt = mid.add_shamt;
      norm_exp   = mid.tent_exp;
    end
  end

  assign sum_shifted = {1'b0, mid.sum} << norm_shamt;

  // Leading one may still sit one place off the MSB
  always_comb begin : small_norm
    {final_man, sticky_bits} = sum_shifted[`FMA_SUM_WIDTH-1:0];
    final_exp                = norm_exp;
    if (sum_shifted[`FMA_SUM_WIDTH]) begin
      {final_man, sticky_bits} = sum_shifted[`FMA_SUM_WIDTH:1];
      final_exp                = `FMA_EXP_WIDTH'(norm_exp + 1);
    end else if (sum_shifted[`FMA_SUM_WIDTH-1]) begin
      // already normal
    end else if (norm_exp > 1) begin
      {final_man, sticky_bits} = {sum_shifted[`FMA_SUM_WIDTH-2:0], 1'b0};
      final_exp                = `FMA_EXP_WIDTH'(norm_exp - 1);
    end else begin
      final_exp = '0;
    end
  end

  assign sticky_after = (|sticky_bits) | mid.sticky;

  // ----------------------------
  // Rounding
  // ----------------------------
  // Overflow before rounding starts from the largest finite value
  assign of_before = final_exp >= (2**`FMA_EXP_BITS - 1);
  assign pre_exp   = of_before ? `FMA_EXP_BITS'(2**`FMA_EXP_BITS - 2)
                               : final_exp[`FMA_EXP_BITS-1:0];
  assign pre_man   = of_before ? '1 : final_man[`FMA_MAN_BITS:1];
  assign pre_abs   = {pre_exp, pre_man};
  // Forced round and sticky let the mode pick infinity or max
  assign rs        = of_before ? 2'b11 : {final_man[0], sticky_after};

  always_comb begin : round_decision
    unique case (mid.rnd_mode)
      RNE:     round_up = rs[1] && (rs[0] || pre_abs[0]);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|rs) && mid.final_sign;
      RUP:     round_up = (|rs) && !mid.final_sign;
      RMM:     round_up = rs[1];
      default: round_up = 1'b0;
    endcase
  end

  // Mantissa carry ripples into the exponent
  assign rounded_abs  = pre_abs + {{(`FMA_WIDTH-2){1'b0}}, round_up};
  // Exact zero from cancellation is -0 only under RDN
  assign exact_zero   = (pre_abs == '0) && (rs == 2'b00);
  assign rounded_sign = (exact_zero && mid.eff_sub) ? (mid.rnd_mode == RDN) : mid.final_sign;

  // Tininess after rounding
  assign uf_after = rounded_abs[`FMA_WIDTH-2:`FMA_MAN_BITS] == '0;
  assign of_after = rounded_abs[`FMA_WIDTH-2:`FMA_MAN_BITS] == '1;

  // ----------------------------
  // Flags and result select
  // ----------------------------
  assign regular_status.nv = 1'b0;
  assign regular_status.of = of_before | of_after;
  assign regular_status.nx = (|rs) | of_before | of_after;
  assign regular_status.uf = uf_after & regular_status.nx;

  assign result_o = mid.is_special ? mid.special_result : {rounded_sign, rounded_abs};
  assign status_o = mid.is_special ? mid.special_status : regular_status;

endmodule

`default_nettype wire

//--- logic/fma_unit.sv
// Binary32 fused multiply-add with two register stages and valid/ready handshake
// Result appears two cycles after acceptance when the output is not stalled
`default_nettype none

`include "fma_defs.svh"

module fma_unit import fma_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  // Operand 0 is a, 1 is b, 2 is c
  input  fp_t [2:0]   operands_i,
  input  fp_op_e      op_i,
  input  logic        op_mod_i,
  input  round_mode_e rnd_mode_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  output fp_t         result_o,
  output status_t     status_o,
  output logic        out_valid_o,
  input  logic        out_ready_i
);

  fma_oper_if oper ();
  fma_mid_if  mid_d ();
  fma_mid_if  mid_q ();

  logic    mid_valid_q;
  logic    mid_ready;
  fp_t     result_d;
  status_t status_d;

  // ----------------------------
  // First stage logic
  // ----------------------------
  fma_operand_prep u_prep (
    .operands_i (operands_i),
    .op_i       (op_i),
    .op_mod_i   (op_mod_i),
    .rnd_mode_i (rnd_mode_i),
    .oper       (oper.prep),
    .mid        (mid_d.spec)
  );

  fma_align_add u_align (
    .oper (oper.align),
    .mid  (mid_d.datapath)
  );

  // ----------------------------
  // Handshake chain
  // ----------------------------
  // A stage moves when downstream is ready or holds a bubble
  assign mid_ready  = out_ready_i | ~out_valid_o;
  assign in_ready_o = mid_ready | ~mid_valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mid_valid_q <= 1'b0;
      out_valid_o <= 1'b0;
    end else begin
      if (in_ready_o) begin
        mid_valid_q <= in_valid_i;
      end
      if (mid_ready) begin
        out_valid_o <= mid_valid_q;
      end
    end
  end

  // Mid payload, loads on an accepted input beat
  always_ff @(posedge clk_i) begin
    if (in_ready_o && in_valid_i) begin
      mid_q.eff_sub        <= mid_d.eff_sub;
      mid_q.exp_prod       <= mid_d.exp_prod;
      mid_q.exp_diff       <= mid_d.exp_diff;
      mid_q.tent_exp       <= mid_d.tent_exp;
      mid_q.add_shamt      <= mid_d.add_shamt;
      mid_q.sticky         <= mid_d.sticky;
      mid_q.sum            <= mid_d.sum;
      mid_q.final_sign     <= mid_d.final_sign;
      mid_q.rnd_mode       <= mid_d.rnd_mode;
      mid_q.is_special     <= mid_d.is_special;
      mid_q.special_result <= mid_d.special_result;
      mid_q.special_status <= mid_d.special_status;
    end
  end

  // ----------------------------
  // Second stage logic
  // ----------------------------
  fma_normalize_round u_norm (
    .mid      (mid_q.norm),
    .result_o (result_d),
    .status_o (status_d)
  );

  // Output register holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (mid_ready && mid_valid_q) begin
      result_o <= result_d;
      status_o <= status_d;
    end
  end

endmodule

`default_nettype wire

//--- sim/fma_unit_chk.sv
// Handshake and reset assertions for the FMA top level
// Bound into fma_unit by the testbench
`default_nettype none

module fma_unit_chk import fma_pkg::*; (
  input logic    clk_i,
  input logic    rst_i,
  input logic    in_ready_i,
  input logic    mid_valid_i,
  input logic    out_valid_i,
  input logic    out_ready_i,
  input fp_t     result_i,
  input status_t status_i
);

  // Running count of failed assertions
  int unsigned failures = 0;

  // A reset edge clears both stage valids
  reset_clears_valid: assert property (@(posedge clk_i)
    rst_i |=> (!mid_valid_i && !out_valid_i))
    else begin
      failures++;
      $error("Stage valid still set after a reset cycle");
    end

  // Stalled output keeps its data
  stalled_output_holds: assert property (@(posedge clk_i) disable iff (rst_i)
    (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(result_i) && $stable(status_i)))
    else begin
      failures++;
      $error("Output changed while stalled by out_ready low");
    end

  // Output empties when its item leaves and nothing waits behind it
  output_drains: assert property (@(posedge clk_i) disable iff (rst_i)
    (out_valid_i && out_ready_i && !mid_valid_i) |=> !out_valid_i)
    else begin
      failures++;
      $error("out_valid stayed high with no item left in the pipeline");
    end

endmodule

`default_nettype wire

//--- sim/fma_unit_tb.sv
// Testbench for the binary32 fused multiply-add unit
// Reads sim/fma_unit_vectors.txt, so run it from the project root
`default_nettype none

module fma_unit_tb import fma_pkg::*; ();

  localparam int MAX_VECTORS  = 64;
  localparam int VEC_WORDS    = 8;
  localparam int RESET_CYCLES = 10;

  logic        clk;
  logic        rst;
  fp_t [2:0]   operands;
  fp_op_e      op;
  logic        op_mod;
  round_mode_e rnd_mode;
  logic        in_valid;
  logic        in_ready;
  fp_t         result;
  status_t     status;
  logic        out_valid;
  logic        out_ready;

  // Per vector: op, op_mod, rnd_mode, a, b, c, result, status
  logic [31:0] vec_mem [0:MAX_VECTORS*VEC_WORDS-1];
  int          vec_count;
  logic        loaded;
  logic [31:0] lfsr_state;
  // Vector index on the input port right now
  int          send_idx;
  // Input handshake seen before the coming edge
  logic        beat_taken;
  int          expected_q[$];
  int          results_seen;
  int          value_errors;
  int          protocol_errors;

  fma_unit UUT (
    .clk_i       (clk),
    .rst_i       (rst),
    .operands_i  (operands),
    .op_i        (op),
    .op_mod_i    (op_mod),
    .rnd_mode_i  (rnd_mode),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .result_o    (result),
    .status_o    (status),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready)
  );

  bind fma_unit fma_unit_chk u_chk (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_ready_i  (in_ready_o),
    .mid_valid_i (mid_valid_q),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_i    (result_o),
    .status_i    (status_o)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic take_bit(output logic value);
    lfsr_state = lfsr_step(lfsr_state);
    value      = lfsr_state[0];
  endtask

  task automatic compare_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("[ERROR] %0t: %s expected %h, got %h", $time, what, expected, actual);
    end
  endtask

  // Unused words keep an address-dependent pattern, never a valid op
  task automatic load_vectors();
    for (int i = 0; i < MAX_VECTORS * VEC_WORDS; i++) begin
      vec_mem[i] = 32'hEE000000 | i;
    end
    $readmemh("sim/fma_unit_vectors.txt", vec_mem);
    vec_count = 0;
    while (vec_count < MAX_VECTORS && vec_mem[vec_count * VEC_WORDS] <= 32'd3) begin
      vec_count++;
    end
  endtask

  task automatic drive_vector(input int idx);
    int base;
    base = idx * VEC_WORDS;
    op          <= fp_op_e'(vec_mem[base][1:0]);
    op_mod      <= vec_mem[base + 1][0];
    rnd_mode    <= round_mode_e'(vec_mem[base + 2][2:0]);
    operands[0] <= vec_mem[base + 3];
    operands[1] <= vec_mem[base + 4];
    operands[2] <= vec_mem[base + 5];
  endtask

  // ------------------------------
  // Scoreboard, mid-cycle sampling
  // ------------------------------
  always @(negedge clk) begin : scoreboard
    int idx;
    beat_taken = !rst && in_valid && in_ready;
    if (beat_taken) begin
      expected_q.push_back(send_idx);
    end
    if (!rst && out_valid && out_ready) begin
      if (expected_q.size() == 0) begin
        protocol_errors++;
        $display("A result came out at %0t with no accepted input waiting for it", $time);
      end else begin
        idx = expected_q.pop_front();
        compare_value($sformatf("vector %0d result", idx), vec_mem[idx * VEC_WORDS + 6],
                      result);
        compare_value($sformatf("vector %0d status", idx), vec_mem[idx * VEC_WORDS + 7],
                      {28'd0, status});
        results_seen++;
      end
    end
  end

  // ------------------------------
  // Stimulus and verdict
  // ------------------------------
  initial begin : stimulus
    logic coin;
    int   total_errors;
    rst             = 1'b1;
    in_valid        = 1'b0;
    out_ready       = 1'b0;
    operands        = '0;
    op              = FMADD;
    op_mod          = 1'b0;
    rnd_mode        = RNE;
    loaded          = 1'b0;
    lfsr_state      = 32'h3dfbc3fc;
    send_idx        = 0;
    results_seen    = 0;
    value_errors    = 0;
    protocol_errors = 0;
    load_vectors();
    if (vec_count == 0) begin
      $display("No test vectors were found in sim/fma_unit_vectors.txt");
      $display("TEST FAIL");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      compare_value("out_valid after reset", 32'd0, {31'd0, out_valid});
      compare_value("in_ready after reset", 32'd1, {31'd0, in_ready});
      // Single beat with the output always ready, two cycles of latency
      @(posedge clk);
      drive_vector(0);
      in_valid  <= 1'b1;
      out_ready <= 1'b1;
      @(negedge clk);
      compare_value("in_ready with an empty pipeline", 32'd1, {31'd0, in_ready});
      @(posedge clk);
      in_valid <= 1'b0;
      @(negedge clk);
      compare_value("out_valid one cycle after accept", 32'd0, {31'd0, out_valid});
      @(negedge clk);
      compare_value("out_valid two cycles after accept", 32'd1, {31'd0, out_valid});
      // Random valid and back-pressure over all vectors
      while (send_idx < vec_count) begin
        @(posedge clk);
        if (beat_taken) begin
          send_idx++;
        end
        take_bit(coin);
        out_ready <= coin;
        // A pending beat stays on the port until it is taken
        if (!in_valid || beat_taken) begin
          take_bit(coin);
          if (send_idx < vec_count && coin) begin
            drive_vector(send_idx);
            in_valid <= 1'b1;
          end else begin
            in_valid <= 1'b0;
          end
        end
      end
      // Drain, still with random back-pressure
      while (results_seen < vec_count + 1) begin
        @(posedge clk);
        take_bit(coin);
        out_ready <= coin;
      end
      total_errors = value_errors + protocol_errors + UUT.u_chk.failures;
      $display("Results checked %0d, value errors %0d, protocol errors %0d, assertion failures %0d",
               results_seen, value_errors, protocol_errors, UUT.u_chk.failures);
      if (total_errors == 0) begin
        $display("TEST PASS");
      end else begin
        $display("TEST FAIL");
      end
      $finish;
    end
  end

  // Run length scales with the vector count
  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = 20 * vec_count + 50;
    repeat (limit) @(posedge clk);
    $display("Timeout after %0d cycles, %0d of %0d results seen", limit, results_seen,
             vec_count + 1);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/fma_unit_vectors.txt
// op op_mod rnd_mode a b c expected_result expected_status, all hex
// op 0 FMADD 1 FNMSUB 2 ADD 3 MUL, rnd 0 RNE 1 RTZ 2 RDN 3 RUP 4 RMM, status {nv,of,uf,nx}
0 0 0 40000000 40400000 3F800000 40E00000 0
0 1 0 40000000 40400000 3F800000 40A00000 0
1 0 0 40000000 40400000 3F800000 C0A00000 0
1 1 0 40000000 40400000 3F800000 C0E00000 0
2 0 0 00000000 3FC00000 40200000 40800000 0
2 1 0 00000000 3FC00000 40200000 BF800000 0
3 0 0 40400000 40800000 00000000 41400000 0
3 0 2 00000000 BF800000 00000000 80000000 0
3 0 0 00000000 3F800000 00000000 00000000 0
2 0 0 00000000 3F800000 33800000 3F800000 1
2 0 0 00000000 3F800001 33800000 3F800002 1
2 0 0 00000000 3F800000 33C00000 3F800001 1
2 0 2 00000000 BF800000 B3800000 BF800001 1
2 0 3 00000000 3F800000 33800000 3F800001 1
2 0 4 00000000 3F800000 33800000 3F800001 1
0 0 3 3F800001 3F800001 BF800000 34800001 1
3 0 0 7F7FFFFF 40000000 00000000 7F800000 5
3 0 1 7F7FFFFF 40000000 00000000 7F7FFFFF 5
3 0 2 FF7FFFFF 40000000 00000000 FF800000 5
3 0 3 FF7FFFFF 40000000 00000000 FF7FFFFF 5
3 0 0 00800000 3F000000 00000000 00400000 0
3 0 0 00800001 3F000000 00000000 00400000 3
3 0 3 00800001 3F000000 00000000 00400001 3
0 0 0 7FC00000 3F800000 3F800000 7FC00000 0
0 0 0 3F800000 3F800000 7F800001 7FC00000 8
0 0 0 7F800000 00000000 3F800000 7FC00000 8
0 0 0 7F800000 3F800000 FF800000 7FC00000 8
0 0 0 FF800000 40000000 3F800000 FF800000 0
0 0 0 40000000 40000000 FF800000 FF800000 0

//--- fma_unit.f
+incdir+logic
logic/fma_pkg.sv
logic/fma_oper_if.sv
logic/fma_mid_if.sv
logic/fma_operand_prep.sv
logic/fma_align_add.sv
logic/fma_normalize_round.sv
logic/fma_unit.sv
sim/fma_unit_chk.sv
sim/fma_unit_tb.sv
